/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;

	// RV32I major opcodes in use
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OPIMM  = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

	typedef enum logic [1:0] {JMP_NONE, JMP_BEQ, JMP_BNE, JMP_JAL} jmp_op_t;

	// Ordered, higher code wins
	typedef enum logic [1:0] {
		HOLD_NONE = 2'd0,
		HOLD_IF   = 2'd1,
		HOLD_ID   = 2'd2
	} hold_code_t;

	// All zero is a bubble
	typedef struct packed {
		alu_op_t   alu_op;
		word_t     op_a;
		word_t     op_b;
		word_t     store_data;
		word_t     imm;
		word_t     pc;
		reg_addr_t rd;
		logic      reg_wr_en;
		mem_op_t   mem_op;
		jmp_op_t   jmp_op;
	} id_ex_t;

endpackage

`default_nettype wire

/* design/pc.sv */
`timescale 1ns/1ps
`default_nettype none

module pc import core_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  wire             clk,
	input  wire             arst_n_i,
	input  wire hold_code_t hold_code_i,
	input  wire             jmp_en_i,
	input  wire word_t      jmp_to_i,
	output word_t           pc_o
);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= RESET_PC;
		end else if (jmp_en_i) begin
			// Redirect beats any hold
			pc_o <= jmp_to_i;
		end else if (hold_code_i == HOLD_NONE) begin
			pc_o <= pc_o + 32'd4;
		end
	end

endmodule

`default_nettype wire

/* design/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage import core_pkg::*; (
	input  wire             clk,
	input  wire             arst_n_i,
	input  wire hold_code_t hold_code_i,
	input  wire word_t      instr_i,
	input  wire word_t      pc_i,
	input  wire word_t      rs1_data_i,
	input  wire word_t      rs2_data_i,
	input  wire             fwd_valid_i,
	input  wire reg_addr_t  fwd_rd_i,
	input  wire word_t      fwd_data_i,
	output reg_addr_t       rs1_addr_o,
	output reg_addr_t       rs2_addr_o,
	output id_ex_t          id_ex_o,
	output logic            load_bypass_o
);

	opcode_t   opcode;
	logic [2:0] funct3;
	reg_addr_t rd;
	word_t     imm_i;
	word_t     imm_s;
	word_t     imm_b;
	word_t     imm_u;
	word_t     imm_j;
	word_t     rs1_val;
	word_t     rs2_val;
	logic      use_rs1;
	logic      use_rs2;
	id_ex_t    id_ex_d;
	id_ex_t    id_ex_q;

	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
		alu_op_t op;
		case (f3)
			3'b000:  op = sub ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b100:  op = ALU_XOR;
			3'b101:  op = ALU_SRL;
			3'b110:  op = ALU_OR;
			3'b111:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	assign opcode     = instr_i[6:0];
	assign funct3     = instr_i[14:12];
	assign rd         = instr_i[11:7];
	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'h000};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	// Result still in execute takes precedence over the register file
	assign rs1_val = (fwd_valid_i && fwd_rd_i == rs1_addr_o) ? fwd_data_i : rs1_data_i;
	assign rs2_val = (fwd_valid_i && fwd_rd_i == rs2_addr_o) ? fwd_data_i : rs2_data_i;

	always_comb begin
		id_ex_d = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		id_ex_d.pc = pc_i;
		id_ex_d.rd = rd;
		case (opcode)
			OPC_OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				id_ex_d.alu_op = alu_sel(funct3, instr_i[30]);
				id_ex_d.op_a = rs1_val;
				id_ex_d.op_b = rs2_val;
				id_ex_d.reg_wr_en = (rd != '0);
			end
			OPC_OPIMM: begin
				use_rs1 = 1'b1;
				id_ex_d.alu_op = alu_sel(funct3, 1'b0);
				id_ex_d.op_a = rs1_val;
				id_ex_d.op_b = imm_i;
				id_ex_d.imm = imm_i;
				id_ex_d.reg_wr_en = (rd != '0);
			end
			OPC_LUI: begin
				id_ex_d.alu_op = ALU_PASS_B;
				id_ex_d.op_b = imm_u;
				id_ex_d.reg_wr_en = (rd != '0);
			end
			OPC_LOAD: begin
				use_rs1 = 1'b1;
				id_ex_d.op_a = rs1_val;
				id_ex_d.imm = imm_i;
				id_ex_d.mem_op = MEM_LOAD;
				id_ex_d.reg_wr_en = (rd != '0);
			end
			OPC_STORE: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				id_ex_d.op_a = rs1_val;
				id_ex_d.store_data = rs2_val;
				id_ex_d.imm = imm_s;
				id_ex_d.mem_op = MEM_STORE;
			end
			OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				id_ex_d.op_a = rs1_val;
				id_ex_d.op_b = rs2_val;
				id_ex_d.imm = imm_b;
				if (funct3 == 3'b000) begin
					id_ex_d.jmp_op = JMP_BEQ;
				end else if (funct3 == 3'b001) begin
					id_ex_d.jmp_op = JMP_BNE;
				end
			end
			OPC_JAL: begin
				// Link value pc + 4 comes out of the ALU
				id_ex_d.op_a = pc_i;
				id_ex_d.op_b = 32'd4;
				id_ex_d.imm = imm_j;
				id_ex_d.jmp_op = JMP_JAL;
				id_ex_d.reg_wr_en = (rd != '0);
			end
			default: id_ex_d.rd = '0;
		endcase
	end

	// Load in execute feeding this instruction
	assign load_bypass_o = id_ex_q.mem_op == MEM_LOAD && id_ex_q.reg_wr_en &&
		((use_rs1 && rs1_addr_o == id_ex_q.rd) || (use_rs2 && rs2_addr_o == id_ex_q.rd));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_q <= '0;
		end else if (hold_code_i != HOLD_NONE) begin
			id_ex_q <= '0;
		end else begin
			id_ex_q <= id_ex_d;
		end
	end

	assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

/* design/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage import core_pkg::*; (
	input  wire id_ex_t id_ex_i,
	input  wire word_t  data_mem_i,
	output word_t       alu_result_o,
	output word_t       addr_mem_o,
	output word_t       data_mem_wr_o,
	output logic        mem_state_o,
	output logic        jmp_en_o,
	output word_t       jmp_to_o,
	output logic        reg_wr_en_o,
	output reg_addr_t   reg_wr_addr_o,
	output word_t       reg_wr_data_o
);

	word_t alu_out;
	logic  op_eq;

	always_comb begin
		case (id_ex_i.alu_op)
			ALU_ADD:    alu_out = id_ex_i.op_a + id_ex_i.op_b;
			ALU_SUB:    alu_out = id_ex_i.op_a - id_ex_i.op_b;
			ALU_AND:    alu_out = id_ex_i.op_a & id_ex_i.op_b;
			ALU_OR:     alu_out = id_ex_i.op_a | id_ex_i.op_b;
			ALU_XOR:    alu_out = id_ex_i.op_a ^ id_ex_i.op_b;
			ALU_SLL:    alu_out = id_ex_i.op_a << id_ex_i.op_b[4:0];
			ALU_SRL:    alu_out = id_ex_i.op_a >> id_ex_i.op_b[4:0];
			ALU_PASS_B: alu_out = id_ex_i.op_b;
			default:    alu_out = '0;
		endcase
	end

	assign op_eq = (id_ex_i.op_a == id_ex_i.op_b);

	always_comb begin
		case (id_ex_i.jmp_op)
			JMP_BEQ: jmp_en_o = op_eq;
			JMP_BNE: jmp_en_o = !op_eq;
			JMP_JAL: jmp_en_o = 1'b1;
			default: jmp_en_o = 1'b0;
		endcase
	end

	// Branch and JAL share one target adder
	assign jmp_to_o = id_ex_i.pc + id_ex_i.imm;

	assign addr_mem_o    = id_ex_i.op_a + id_ex_i.imm;
	assign data_mem_wr_o = id_ex_i.store_data;
	assign mem_state_o   = (id_ex_i.mem_op == MEM_STORE);

	// Execute result, load data included, also feeds the bypass
	assign alu_result_o = (id_ex_i.mem_op == MEM_LOAD) ? data_mem_i : alu_out;

	assign reg_wr_en_o   = id_ex_i.reg_wr_en;
	assign reg_wr_addr_o = id_ex_i.rd;
	assign reg_wr_data_o = alu_result_o;

endmodule

`default_nettype wire

/* design/regs.sv */
`timescale 1ns/1ps
`default_nettype none

module regs import core_pkg::*; (
	input  wire            clk,
	input  wire            arst_n_i,
	input  wire            wr_en_i,
	input  wire reg_addr_t wr_addr_i,
	input  wire word_t     wr_data_i,
	input  wire reg_addr_t rd1_addr_i,
	input  wire reg_addr_t rd2_addr_i,
	output word_t          rd1_data_o,
	output word_t          rd2_data_o
);

	word_t mem [1:31];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// Write-through on a same-cycle address match
	always_comb begin
		if (rd1_addr_i == '0) begin
			rd1_data_o = '0;
		end else if (wr_en_i && wr_addr_i == rd1_addr_i) begin
			rd1_data_o = wr_data_i;
		end else begin
			rd1_data_o = mem[rd1_addr_i];
		end
		if (rd2_addr_i == '0) begin
			rd2_data_o = '0;
		end else if (wr_en_i && wr_addr_i == rd2_addr_i) begin
			rd2_data_o = wr_data_i;
		end else begin
			rd2_data_o = mem[rd2_addr_i];
		end
	end

endmodule

`default_nettype wire

/* design/ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl import core_pkg::*; (
	input  wire        jmp_en_i,
	input  wire word_t jmp_to_i,
	input  wire        load_bypass_i,
	output logic       jmp_en_o,
	output word_t      jmp_to_o,
	output hold_code_t hold_code_o
);

	always_comb begin
		jmp_en_o = jmp_en_i;
		jmp_to_o = jmp_to_i;
		// A flush drops the stalled instruction, so no stall with it
		if (jmp_en_i) begin
			hold_code_o = HOLD_ID;
		end else if (load_bypass_i) begin
			hold_code_o = HOLD_IF;
		end else begin
			hold_code_o = HOLD_NONE;
		end
	end

endmodule

`default_nettype wire

/* design/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; #(
	parameter word_t RESET_PC = 32'h0000_0000
) (
	input  wire        clk,
	input  wire        arst_n_i,
	input  wire word_t instr_i,
	input  wire word_t data_mem_i,
	output word_t      pc_o,
	output logic       instr_rd_en_o,
	output word_t      addr_mem_o,
	output word_t      data_mem_wr_o,
	output logic       mem_state_o
);

	hold_code_t hold_code;
	logic       jmp_en_ex;
	word_t      jmp_to_ex;
	logic       jmp_en_pc;
	word_t      jmp_to_pc;
	logic       load_bypass;
	reg_addr_t  rs1_addr;
	reg_addr_t  rs2_addr;
	word_t      rs1_data;
	word_t      rs2_data;
	id_ex_t     id_ex;
	word_t      ex_result;
	logic       reg_wr_en;
	reg_addr_t  reg_wr_addr;
	word_t      reg_wr_data;

	assign instr_rd_en_o = (hold_code < HOLD_IF);

	pc #(
		.RESET_PC (RESET_PC)
	) core_pc (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.hold_code_i (hold_code),
		.jmp_en_i    (jmp_en_pc),
		.jmp_to_i    (jmp_to_pc),
		.pc_o        (pc_o)
	);

	id_stage core_id (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.hold_code_i   (hold_code),
		.instr_i       (instr_i),
		.pc_i          (pc_o),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.fwd_valid_i   (reg_wr_en),
		.fwd_rd_i      (reg_wr_addr),
		.fwd_data_i    (ex_result),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.id_ex_o       (id_ex),
		.load_bypass_o (load_bypass)
	);

	ex_stage core_ex (
		.id_ex_i       (id_ex),
		.data_mem_i    (data_mem_i),
		.alu_result_o  (ex_result),
		.addr_mem_o    (addr_mem_o),
		.data_mem_wr_o (data_mem_wr_o),
		.mem_state_o   (mem_state_o),
		.jmp_en_o      (jmp_en_ex),
		.jmp_to_o      (jmp_to_ex),
		.reg_wr_en_o   (reg_wr_en),
		.reg_wr_addr_o (reg_wr_addr),
		.reg_wr_data_o (reg_wr_data)
	);

	regs general_regs (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (reg_wr_en),
		.wr_addr_i  (reg_wr_addr),
		.wr_data_i  (reg_wr_data),
		.rd1_addr_i (rs1_addr),
		.rd2_addr_i (rs2_addr),
		.rd1_data_o (rs1_data),
		.rd2_data_o (rs2_data)
	);

	ctrl core_ctrl (
		.jmp_en_i      (jmp_en_ex),
		.jmp_to_i      (jmp_to_ex),
		.load_bypass_i (load_bypass),
		.jmp_en_o      (jmp_en_pc),
		.jmp_to_o      (jmp_to_pc),
		.hold_code_o   (hold_code)
	);

endmodule

`default_nettype wire

/* testbench/core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module core_checker import core_pkg::*; (
	input wire             clk,
	input wire             arst_n_i,
	input wire             mem_state_i,
	input wire             reg_wr_en_i,
	input wire reg_addr_t  reg_wr_addr_i,
	input wire             jmp_en_i,
	input wire hold_code_t hold_code_i
);

	// A store never writes back
	store_no_wb: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_state_i |-> !reg_wr_en_i)
		else $error("Store in execute together with a register write");

	// The flushed slot reaches execute as a bubble
	jump_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
		jmp_en_i |-> hold_code_i == HOLD_ID ##1 (!mem_state_i && !reg_wr_en_i && !jmp_en_i))
		else $error("Jump without the HOLD_ID code or without a bubble behind it");

	// x0 stays zero
	no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		reg_wr_en_i |-> reg_wr_addr_i != '0)
		else $error("Register write aimed at x0");

endmodule

bind core core_checker core_checks (
	.clk           (clk),
	.arst_n_i      (arst_n_i),
	.mem_state_i   (mem_state_o),
	.reg_wr_en_i   (reg_wr_en),
	.reg_wr_addr_i (reg_wr_addr),
	.jmp_en_i      (jmp_en_ex),
	.hold_code_i   (hold_code)
);

`default_nettype wire

/* testbench/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import core_pkg::*; ();

	localparam int    TIMEOUT_CYCLES = 2000;
	localparam word_t MARKER_ADDR    = 32'h0000_00fc;

	typedef struct packed {
		logic [127:0] name;
		word_t        addr;
		word_t        data;
	} store_rec_t;

	logic  clk;
	logic  arst_n;
	word_t instr;
	word_t data_mem_rd;
	word_t pc;
	logic  instr_rd_en;
	word_t addr_mem;
	word_t data_mem_wr;
	logic  mem_state;

	word_t      imem [0:255];
	word_t      dmem [0:63];
	store_rec_t expected [$];
	int         record_count;
	int         store_count;
	int         check_errors;
	int         run_errors;
	logic       marker_seen;
	word_t      prev_pc;
	logic       prev_rd_en;
	logic       fetch_valid;

	core #(
		.RESET_PC (32'h0000_0000)
	) core_inst (
		.clk           (clk),
		.arst_n_i      (arst_n),
		.instr_i       (instr),
		.data_mem_i    (data_mem_rd),
		.pc_o          (pc),
		.instr_rd_en_o (instr_rd_en),
		.addr_mem_o    (addr_mem),
		.data_mem_wr_o (data_mem_wr),
		.mem_state_o   (mem_state)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Both memories answer in the same cycle
	assign instr       = imem[pc[9:2]];
	assign data_mem_rd = dmem[addr_mem[7:2]];

	always @(posedge clk) begin
		if (!arst_n) begin
			for (int i = 0; i < 64; i++) begin
				dmem[i] <= '0;
			end
		end else if (mem_state) begin
			dmem[addr_mem[7:2]] <= data_mem_wr;
		end
	end

	task automatic check_value(input logic [127:0] name, input string field,
		input word_t exp_val, input word_t act_val);
		if (exp_val !== act_val) begin
			$display("[FAIL] %0s %0s: expected %h, actual %h",
				name, field, exp_val, act_val);
			check_errors++;
		end
	endtask

	// Each store pops the next expected record
	always @(posedge clk) begin
		store_rec_t rec;
		if (!arst_n) begin
			store_count = 0;
			check_errors = 0;
			marker_seen <= 1'b0;
		end else if (mem_state) begin
			store_count++;
			if (expected.size() == 0) begin
				$display("Store of %h to %h came after the last expected store",
					data_mem_wr, addr_mem);
				check_errors++;
			end else begin
				rec = expected.pop_front();
				check_value(rec.name, "address", rec.addr, addr_mem);
				check_value(rec.name, "data", rec.data, data_mem_wr);
			end
			if (addr_mem == MARKER_ADDR) begin
				marker_seen <= 1'b1;
			end
		end
	end

	// A granted fetch steps the PC by 4 and a hold never lasts two cycles
	always @(posedge clk) begin
		if (!arst_n) begin
			fetch_valid <= 1'b0;
		end else begin
			if (fetch_valid && prev_rd_en) begin
				check_value("fetch", "pc", prev_pc + 32'd4, pc);
			end
			if (fetch_valid && !prev_rd_en && !instr_rd_en) begin
				$display("Instruction read enable stayed low for two cycles at pc %h", pc);
				check_errors++;
			end
			fetch_valid <= 1'b1;
			prev_pc <= pc;
			prev_rd_en <= instr_rd_en;
		end
	end

	task automatic load_tests();
		int               fd;
		int               idx;
		int               k;
		logic [63:0]      kind;
		logic [8*128-1:0] rest;
		logic [127:0]     name;
		word_t            word;
		word_t            addr;
		word_t            data;
		for (idx = 0; idx < 256; idx++) begin
			imem[idx] = '0;
		end
		idx = 0;
		fd = $fopen("testbench/core_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file testbench/core_tests.txt");
			run_errors++;
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "#") begin
					void'($fgets(rest, fd));
				end else if (kind == "P") begin
					for (k = 0; k < 4; k++) begin
						void'($fscanf(fd, "%h", word));
						imem[idx] = word;
						idx++;
					end
				end else if (kind == "S") begin
					void'($fscanf(fd, "%s %h %h", name, addr, data));
					expected.push_back(store_rec_t'{name: name, addr: addr, data: data});
				end else begin
					$display("Unknown record kind in the test file");
					run_errors++;
				end
			end
			$fclose(fd);
		end
		record_count = expected.size();
	endtask

	initial begin
		int cycles;
		arst_n = 1'b0;
		run_errors = 0;
		load_tests();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		cycles = 0;
		while (!marker_seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (!marker_seen) begin
			$display("Timed out after %0d cycles waiting for the store to the marker address",
				cycles);
			run_errors++;
		end
		if (expected.size() != 0) begin
			$display("%0d expected stores never happened", expected.size());
			run_errors++;
		end
		$display("Stores: %0d of %0d, check errors: %0d, other errors: %0d",
			store_count, record_count, check_errors, run_errors);
		if (check_errors == 0 && run_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/core_tests.txt */
# P: four program words in hex, from address 0 upward
# S: test name, store address and store data in hex, in program order
# ALU, forwarding and LUI
P 12300093 00508113 401101b3 00302023
P abcde237 12326213 0ff24293 7f02f293
P 00502223 00325333 00331333 00435393
P 00839393 00702423 00734433 00146433
# Load-use and x0
P 00447433 00240433 00802623 00c02483
P 00148493 00902823 04d00013 00002a23
# Branches, JAL, marker store and a self loop
P 00118463 00119463 00102c23 00318463
P 00202c23 00109463 0080056f 00102c23
P 00a02c23 0e302e23 0000006f 00000000
S sub_fwd   00000000 00000005
S imm_logic 00000004 000001d0
S shifts    00000008 bcde1200
S reg_alu   0000000c 0301e24b
S load_use  00000010 0301e24c
S x0_write  00000014 00000000
S jal_link  00000018 0000007c
S done      000000fc 00000005

/* project.f */
design/core_pkg.sv
design/pc.sv
design/id_stage.sv
design/ex_stage.sv
design/regs.sv
design/ctrl.sv
design/core.sv
testbench/core_checker.sv
testbench/core_tb.sv

/* Makefile */
TOP = core_tb
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

obj_dir/V$(TOP): project.f $(wildcard design/*.sv testbench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir $(LOG)
